// ==== list.f ====
+incdir+test
src/life_pkg.sv
src/gen_sequencer.sv
src/cell_ram.sv
src/row_window.sv
src/life_cell.sv
src/row_writer.sv
src/life_top.sv
test/tb_life.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the life engine testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
set -o pipefail

rm -rf obj_dir build.log sim.log

verilator --binary -j 0 --top-module tb_life -f list.f -o tb_life 2>&1 | tee build.log &&
	./obj_dir/tb_life 2>&1 | tee sim.log ||
	{ echo "build or simulation did not complete"; exit 1; }

grep -q "TESTBENCH PASSED" sim.log && exit 0 || exit 1

// ==== src/cell_ram.sv ====
// two bank row RAM, one read and one write port
// registered address and output, two cycle read
`timescale 1ns/1ps
`default_nettype none

module cell_ram #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 32
) (
	input  wire                           clk,
	input  wire  [life_pkg::ROW_BITS:0]   rd_addr,
	output logic [WIDTH-1:0]              rd_q,
	input  wire                           we,
	input  wire  [life_pkg::ROW_BITS:0]   wr_addr,
	input  wire  [WIDTH-1:0]              wr_data
);

	localparam int RB = life_pkg::ROW_BITS;

	// bank 0 in the low half, bank 1 in the high half
	logic [WIDTH-1:0] mem [2*DEPTH];
	logic [RB:0]      rd_addr_q;

	// top bit picks the bank
	function automatic int word_index(input logic [RB:0] addr);
		return (addr[RB] ? DEPTH : 0) + int'(addr[RB-1:0]);
	endfunction

	always_ff @(posedge clk) begin
		if (we) begin
			mem[word_index(wr_addr)] <= wr_data;
		end
		rd_addr_q <= rd_addr;
		rd_q      <= mem[word_index(rd_addr_q)];
	end

endmodule

`default_nettype wire

// ==== src/gen_sequencer.sv ====
// generation sequencer for the life engine
// host row access in idle, row streaming per generation, bank swap and count
`timescale 1ns/1ps
`default_nettype none

module gen_sequencer #(
	parameter int DEPTH = 32
) (
	input  wire                              clk,
	input  wire                              reset,
	input  life_pkg::host_cmd_t              cmd,
	output logic [life_pkg::ROW_BITS:0]      rd_addr,
	output life_pkg::row_ctl_t               ctl,
	output logic                             host_wr,
	output logic [life_pkg::ROW_BITS-1:0]    host_row,
	output logic                             rd_valid,
	output logic                             busy,
	output logic [life_pkg::GEN_BITS-1:0]    gen_count,
	input  wire                              done
);

	localparam int RB = life_pkg::ROW_BITS;
	localparam int GB = life_pkg::GEN_BITS;
	localparam logic [RB-1:0] LAST_ROW = RB'(DEPTH - 1);

	life_pkg::seq_state_e state;
	// prime: read index, stream: centre row being evaluated
	logic [RB-1:0] cnt;
	// bank holding the current board
	logic          bank;
	logic [RB-1:0] rd_row;
	logic          accept;
	logic          host_rd;
	logic          start;
	// rd_valid delay, matches the RAM read latency
	logic [1:0]    rd_pipe;

	////////////////////////////////////////
	// host request decode
	////////////////////////////////////////

	// requests only count in idle
	assign accept = (state == life_pkg::S_IDLE);

	// write beats read beats step/run
	assign host_wr = accept && cmd.wr_req;
	assign host_rd = accept && cmd.rd_req && !cmd.wr_req;
	assign start   = accept && (cmd.step || cmd.run) && !cmd.wr_req && !cmd.rd_req;

	assign host_row = cmd.row;
	assign busy     = (state != life_pkg::S_IDLE);
	assign rd_valid = rd_pipe[1];

	////////////////////////////////////////
	// state, bank and generation count
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= life_pkg::S_IDLE;
			cnt       <= '0;
			bank      <= 1'b0;
			gen_count <= '0;
			rd_pipe   <= '0;
		end else begin
			rd_pipe <= {rd_pipe[0], host_rd};
			case (state)
				life_pkg::S_IDLE: begin
					if (start) begin
						state <= life_pkg::S_PRIME;
						cnt   <= '0;
					end
				end
				life_pkg::S_PRIME: begin
					// two reads, then the window is primed
					if (cnt == RB'(1)) begin
						state <= life_pkg::S_STREAM;
						cnt   <= '0;
					end else begin
						cnt <= cnt + RB'(1);
					end
				end
				life_pkg::S_STREAM: begin
					if (cnt == LAST_ROW) begin
						state <= life_pkg::S_FLUSH;
					end else begin
						cnt <= cnt + RB'(1);
					end
				end
				life_pkg::S_FLUSH: begin
					// last row written, new board becomes current
					if (done) begin
						state     <= life_pkg::S_IDLE;
						bank      <= ~bank;
						gen_count <= gen_count + GB'(1);
					end
				end
				default: state <= life_pkg::S_IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// read address
	////////////////////////////////////////

	// read order DEPTH-1, 0, 1 .. DEPTH-1, 0
	always_comb begin
		case (state)
			life_pkg::S_IDLE:   rd_row = cmd.row;
			life_pkg::S_PRIME:  rd_row = (cnt == '0) ? LAST_ROW : '0;
			// one row ahead of the centre row
			life_pkg::S_STREAM: rd_row = (cnt == LAST_ROW) ? '0 : cnt + RB'(1);
			default:            rd_row = '0;
		endcase
	end

	// always read the current bank
	assign rd_addr = {bank, rd_row};

	// tag for this read, window shifts on every generation read
	always_comb begin
		ctl.shift  = (state == life_pkg::S_PRIME) || (state == life_pkg::S_STREAM);
		ctl.eval   = (state == life_pkg::S_STREAM);
		ctl.wr_row = cnt;
		// new rows go to the other bank
		ctl.bank   = ~bank;
	end

endmodule

`default_nettype wire

// ==== src/life_cell.sv ====
// one column of the cell array
// column sum for the neighbours, nine cell total and the life rule
`timescale 1ns/1ps
`default_nettype none

module life_cell (
	input  wire        clk,
	input  wire        north_bit,
	input  wire        centre_bit,
	input  wire        south_bit,
	input  wire  [1:0] sum_west,
	input  wire  [1:0] sum_east,
	output logic [1:0] sum_own,
	input  wire        eval,
	output logic       next_bit
);

	// own cell included, 0 to 9
	logic [3:0] total;
	logic       alive;

	// three cells of this column
	assign sum_own = {1'b0, north_bit} + {1'b0, centre_bit} + {1'b0, south_bit};

	// neighbour columns give the rest of the 3x3 block
	assign total = {2'b00, sum_west} + {2'b00, sum_own} + {2'b00, sum_east};

	// 3 total is birth or survival on 2,
	// 4 total is survival on 3 only if the centre is alive
	assign alive = (total == 4'd3) || ((total == 4'd4) && centre_bit);

	// hold the result until the next full window
	always_ff @(posedge clk) begin
		if (eval) begin
			next_bit <= alive;
		end
	end

endmodule

`default_nettype wire

// ==== src/life_pkg.sv ====
// life engine shared definitions
// row address and counter widths, sequencer states, host and pipeline control words
`default_nettype none

package life_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	// row address, up to 256 rows per bank
	localparam int ROW_BITS = 8;
	// generation counter
	localparam int GEN_BITS = 48;

	////////////////////////////////////////
	// sequencer states
	////////////////////////////////////////

	typedef enum logic [1:0] {
		S_IDLE   = 2'd0, // host access allowed
		S_PRIME  = 2'd1, // first two wrap reads
		S_STREAM = 2'd2, // one row per cycle, eval on
		S_FLUSH  = 2'd3  // drain pipeline, wait for last write
	} seq_state_e;

	// host controls, 12 bits
	typedef struct packed {
		logic                step;   // one generation, pulse
		logic                run;    // free running, level
		logic                rd_req; // row read, pulse
		logic                wr_req; // row write, pulse
		logic [ROW_BITS-1:0] row;    // row for rd/wr
	} host_cmd_t;

	// control travelling with each row read, 11 bits
	typedef struct packed {
		logic                shift;  // advance the window
		logic                eval;   // window holds a full neighbourhood
		logic [ROW_BITS-1:0] wr_row; // centre row of the window
		logic                bank;   // bank the new row goes to
	} row_ctl_t;

endpackage

`default_nettype wire

// ==== src/life_top.sv ====
// game of life engine, toroidal board of WIDTH x DEPTH cells
// streams rows through a three row window and a row of cell units
`timescale 1ns/1ps
`default_nettype none

module life_top #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 32
) (
	input  wire                              clk,
	input  wire                              reset,
	input  life_pkg::host_cmd_t              cmd,
	input  wire  [WIDTH-1:0]                 wr_data,
	output logic [WIDTH-1:0]                 rd_data,
	output logic                             rd_valid,
	output logic                             busy,
	output logic [life_pkg::GEN_BITS-1:0]    gen_count
);

	////////////////////////////////////////
	// interconnect
	////////////////////////////////////////

	// read side, {bank, row}
	logic [life_pkg::ROW_BITS:0]   rd_addr;
	logic [WIDTH-1:0]              ram_q;
	// write side
	logic                          ram_we;
	logic [life_pkg::ROW_BITS:0]   ram_waddr;
	logic [WIDTH-1:0]              ram_wdata;
	// host write strobe from the sequencer
	logic                          host_wr;
	logic [life_pkg::ROW_BITS-1:0] host_row;
	// pipeline control
	life_pkg::row_ctl_t            seq_ctl;
	life_pkg::row_ctl_t            win_ctl;
	logic                          done;
	// window rows and new row
	logic [WIDTH-1:0]              north;
	logic [WIDTH-1:0]              centre;
	logic [WIDTH-1:0]              south;
	logic [WIDTH-1:0]              next_row;
	// per column 3 cell sums
	logic [1:0]                    col_sum [WIDTH];

	// host reads come straight off the RAM output
	assign rd_data = ram_q;

	gen_sequencer #(
		.DEPTH (DEPTH)
	) u_seq (
		.clk       (clk),
		.reset     (reset),
		.cmd       (cmd),
		.rd_addr   (rd_addr),
		.ctl       (seq_ctl),
		.host_wr   (host_wr),
		.host_row  (host_row),
		.rd_valid  (rd_valid),
		.busy      (busy),
		.gen_count (gen_count),
		.done      (done)
	);

	cell_ram #(
		.WIDTH (WIDTH),
		.DEPTH (DEPTH)
	) u_ram (
		.clk     (clk),
		.rd_addr (rd_addr),
		.rd_q    (ram_q),
		.we      (ram_we),
		.wr_addr (ram_waddr),
		.wr_data (ram_wdata)
	);

	row_window #(
		.WIDTH (WIDTH)
	) u_window (
		.clk     (clk),
		.reset   (reset),
		.rd_q    (ram_q),
		.ctl_in  (seq_ctl),
		.ctl_out (win_ctl),
		.north   (north),
		.centre  (centre),
		.south   (south)
	);

	////////////////////////////////////////
	// cell array, wraps column 0 to WIDTH-1
	////////////////////////////////////////

	for (genvar i = 0; i < WIDTH; i++) begin : g_cell
		localparam int WEST = (i == 0) ? WIDTH - 1 : i - 1;
		localparam int EAST = (i == WIDTH - 1) ? 0 : i + 1;

		life_cell u_cell (
			.clk        (clk),
			.north_bit  (north[i]),
			.centre_bit (centre[i]),
			.south_bit  (south[i]),
			.sum_west   (col_sum[WEST]),
			.sum_east   (col_sum[EAST]),
			.sum_own    (col_sum[i]),
			.eval       (win_ctl.eval),
			.next_bit   (next_row[i])
		);
	end

	// host bank is the bank bit the sequencer puts on the read address
	row_writer #(
		.WIDTH (WIDTH),
		.DEPTH (DEPTH)
	) u_writer (
		.clk       (clk),
		.reset     (reset),
		.next_row  (next_row),
		.ctl       (win_ctl),
		.host_wr   (host_wr),
		.host_row  (host_row),
		.host_bank (rd_addr[life_pkg::ROW_BITS]),
		.wr_data   (wr_data),
		.we        (ram_we),
		.wr_addr   (ram_waddr),
		.ram_wdata (ram_wdata),
		.done      (done)
	);

endmodule

`default_nettype wire

// ==== src/row_window.sv ====
// three row window over the board
// rows enter at the south edge as the RAM returns them
`timescale 1ns/1ps
`default_nettype none

module row_window #(
	parameter int WIDTH = 32
) (
	input  wire                 clk,
	input  wire                 reset,
	input  wire  [WIDTH-1:0]    rd_q,
	input  life_pkg::row_ctl_t  ctl_in,
	output life_pkg::row_ctl_t  ctl_out,
	output logic [WIDTH-1:0]    north,
	output logic [WIDTH-1:0]    centre,
	output logic [WIDTH-1:0]    south
);

	// ctl delayed by the RAM latency
	life_pkg::row_ctl_t ctl_d1;
	life_pkg::row_ctl_t ctl_d2;

	////////////////////////////////////////
	// control alignment
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			ctl_d1  <= '0;
			ctl_d2  <= '0;
			ctl_out <= '0;
		end else begin
			ctl_d1  <= ctl_in;
			// lines up with rd_q
			ctl_d2  <= ctl_d1;
			// lines up with the shifted window
			ctl_out <= ctl_d2;
		end
	end

	// rows move north by one on each returned read
	always_ff @(posedge clk) begin
		if (ctl_d2.shift) begin
			north  <= centre;
			centre <= south;
			south  <= rd_q;
		end
	end

endmodule

`default_nettype wire

// ==== src/row_writer.sv ====
// RAM write port driver
// new rows to the other bank during a generation, host rows otherwise
`timescale 1ns/1ps
`default_nettype none

module row_writer #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 32
) (
	input  wire                              clk,
	input  wire                              reset,
	input  wire  [WIDTH-1:0]                 next_row,
	input  life_pkg::row_ctl_t               ctl,
	input  wire                              host_wr,
	input  wire  [life_pkg::ROW_BITS-1:0]    host_row,
	input  wire                              host_bank,
	input  wire  [WIDTH-1:0]                 wr_data,
	output logic                             we,
	output logic [life_pkg::ROW_BITS:0]      wr_addr,
	output logic [WIDTH-1:0]                 ram_wdata,
	output logic                             done
);

	localparam int RB = life_pkg::ROW_BITS;
	localparam logic [RB-1:0] LAST_ROW = RB'(DEPTH - 1);

	// matches the registered cell outputs
	life_pkg::row_ctl_t ctl_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			ctl_q <= '0;
		end else begin
			ctl_q <= ctl;
		end
	end

	// host writes only arrive in idle, no overlap with new rows
	assign we        = ctl_q.eval || host_wr;
	assign wr_addr   = ctl_q.eval ? {ctl_q.bank, ctl_q.wr_row} : {host_bank, host_row};
	assign ram_wdata = ctl_q.eval ? next_row : wr_data;

	// last row of the generation going in
	assign done = ctl_q.eval && (ctl_q.wr_row == LAST_ROW);

endmodule

`default_nettype wire

// ==== test/tb_life_tasks.svh ====
// life engine testbench tasks
// host port drivers, compares against the model and the directed tests

////////////////////////////////////////
// compares and reporting
////////////////////////////////////////

task automatic check_row(input logic [WIDTH-1:0] got, input logic [WIDTH-1:0] exp, input int row);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("ERROR %0t ns: row %0d reads %h, expected %h", $time, row, got, exp);
	end
endtask

task automatic check_count(input logic [GB-1:0] got, input logic [GB-1:0] exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("ERROR %0t ns: gen_count is %0d, expected %0d", $time, got, exp);
	end
endtask

task automatic report_fault(input string msg);
	errors++;
	$display("at %0t ns: %s", $time, msg);
endtask

task automatic report_test(input string name, input int errs_before);
	tests_run++;
	if (errors == errs_before) begin
		$display("test %0d %s: ok", tests_run, name);
	end else begin
		$display("test %0d %s: failed with %0d errors", tests_run, name, errors - errs_before);
	end
endtask

////////////////////////////////////////
// host port drivers
////////////////////////////////////////

// all drivers start and end just after a falling edge
task automatic write_row(input int row, input logic [WIDTH-1:0] data);
	cmd.wr_req = 1'b1;
	cmd.row    = RB'(row);
	wr_data    = data;
	@(negedge clk);
	cmd.wr_req = 1'b0;
endtask

// rd_valid must be low after one cycle and high after two
task automatic read_row(input int row, output logic [WIDTH-1:0] data, output bit ok);
	cmd.rd_req = 1'b1;
	cmd.row    = RB'(row);
	@(negedge clk);
	cmd.rd_req = 1'b0;
	ok = 1'b1;
	if (rd_valid !== 1'b0) begin
		report_fault($sformatf("rd_valid came one cycle early for row %0d", row));
		ok = 1'b0;
	end
	@(negedge clk);
	data = rd_data;
	if (rd_valid !== 1'b1) begin
		report_fault($sformatf("no rd_valid two cycles after the read of row %0d", row));
		ok = 1'b0;
	end
endtask

task automatic write_board();
	for (int r = 0; r < DEPTH; r++) begin
		write_row(r, board[r]);
	end
endtask

task automatic check_board();
	logic [WIDTH-1:0] data;
	bit ok;
	for (int r = 0; r < DEPTH; r++) begin
		read_row(r, data, ok);
		if (ok) begin
			check_row(data, board[r], r);
		end
	end
endtask

task automatic wait_idle();
	int n;
	n = 0;
	while (busy && n < 2 * (DEPTH + 10)) begin
		@(negedge clk);
		n++;
	end
	if (busy) begin
		report_fault("busy stayed high, generation never finished");
	end
endtask

// steps the DUT one generation and leaves the model alone
task automatic step_generation();
	cmd.step = 1'b1;
	@(negedge clk);
	cmd.step = 1'b0;
	if (busy !== 1'b1) begin
		report_fault("busy did not rise after a step");
	end
	wait_idle();
endtask

task automatic fill_random();
	for (int r = 0; r < DEPTH; r++) begin
		rng_state = xorshift(rng_state);
		board[r]  = rng_state[WIDTH-1:0];
	end
endtask

task automatic clear_board();
	for (int r = 0; r < DEPTH; r++) begin
		board[r] = '0;
	end
endtask

// coordinates wrap on both axes
task automatic set_cell(input int row, input int col);
	board[(row + DEPTH) % DEPTH][(col + WIDTH) % WIDTH] = 1'b1;
endtask

task automatic step_and_compare();
	step_generation();
	model_step();
	check_count(gen_count, exp_gen);
	check_board();
endtask

////////////////////////////////////////
// directed tests
////////////////////////////////////////

task automatic test_write_readback();
	int e0;
	e0 = errors;
	fill_random();
	write_board();
	check_board();
	check_count(gen_count, exp_gen);
	report_test("write and read back", e0);
endtask

task automatic test_patterns();
	int e0;
	e0 = errors;
	// vertical blinker
	clear_board();
	set_cell(3, 7);
	set_cell(4, 7);
	set_cell(5, 7);
	write_board();
	step_and_compare();
	// glider straddling the row and column wrap
	clear_board();
	set_cell(-1, 0);
	set_cell(0, 1);
	set_cell(1, -1);
	set_cell(1, 0);
	set_cell(1, 1);
	write_board();
	step_and_compare();
	// still life block
	clear_board();
	set_cell(8, 4);
	set_cell(8, 5);
	set_cell(9, 4);
	set_cell(9, 5);
	write_board();
	step_and_compare();
	report_test("known patterns", e0);
endtask

task automatic test_random_boards();
	int e0;
	e0 = errors;
	for (int b = 0; b < 3; b++) begin
		fill_random();
		write_board();
		for (int s = 0; s < 5; s++) begin
			step_and_compare();
		end
	end
	report_test("random boards", e0);
endtask

task automatic test_run_level();
	int e0;
	int n;
	int gens;
	bit was_busy;
	e0 = errors;
	n = 0;
	gens = 0;
	was_busy = 1'b0;
	cmd.run = 1'b1;
	// each busy fall ends one generation
	// run drops in the idle cycle after the fifth
	while (gens < 5 && n < 5 * (DEPTH + 10)) begin
		@(negedge clk);
		n++;
		if (was_busy && !busy) begin
			gens++;
		end
		was_busy = busy;
	end
	cmd.run = 1'b0;
	if (gens != 5) begin
		report_fault($sformatf("run level gave %0d generations instead of 5", gens));
	end
	wait_idle();
	for (int g = 0; g < 5; g++) begin
		model_step();
	end
	check_count(gen_count, exp_gen);
	check_board();
	report_test("run level", e0);
endtask

task automatic test_ignored_requests();
	int e0;
	int n;
	e0 = errors;
	cmd.step = 1'b1;
	@(negedge clk);
	cmd.step = 1'b0;
	// a write and a read while busy are both dropped
	write_row(3, ~board[3]);
	cmd.rd_req = 1'b1;
	cmd.row    = RB'(5);
	@(negedge clk);
	cmd.rd_req = 1'b0;
	n = 0;
	while ((busy || n < 3) && n < 2 * (DEPTH + 10)) begin
		if (rd_valid !== 1'b0) begin
			report_fault("rd_valid followed a read issued while busy");
		end
		@(negedge clk);
		n++;
	end
	wait_idle();
	model_step();
	check_count(gen_count, exp_gen);
	check_board();
	report_test("ignored requests", e0);
endtask

// ==== test/tb_life.sv ====
// testbench for the life engine
// reference board model, clock, reset, watchdog and the directed test sequence
`timescale 1ns/1ps
`default_nettype none

module tb_life;

	localparam int WIDTH = 16;
	localparam int DEPTH = 16;
	localparam int RB = life_pkg::ROW_BITS;
	localparam int GB = life_pkg::GEN_BITS;
	localparam int NUM_TESTS = 5;
	// generous bound over all five tests
	localparam int CYCLE_LIMIT = 20 * (NUM_TESTS * (DEPTH + 10) + DEPTH * 4);

	logic                clk;
	logic                reset;
	life_pkg::host_cmd_t cmd;
	logic [WIDTH-1:0]    wr_data;
	logic [WIDTH-1:0]    rd_data;
	logic                rd_valid;
	logic                busy;
	logic [GB-1:0]       gen_count;

	// reference board and expected generation count
	logic [WIDTH-1:0] board [DEPTH];
	logic [GB-1:0]    exp_gen;
	logic [31:0]      rng_state;
	int               errors;
	int               checks;
	int               tests_run;

	life_top #(
		.WIDTH (WIDTH),
		.DEPTH (DEPTH)
	) UUT (
		.clk       (clk),
		.reset     (reset),
		.cmd       (cmd),
		.wr_data   (wr_data),
		.rd_data   (rd_data),
		.rd_valid  (rd_valid),
		.busy      (busy),
		.gen_count (gen_count)
	);

	// 4 ns period
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	// xorshift32 step
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// one toroidal generation of the model board
	task automatic model_step();
		logic [WIDTH-1:0] nb [DEPTH];
		int n;
		int rn;
		int cn;
		for (int r = 0; r < DEPTH; r++) begin
			for (int c = 0; c < WIDTH; c++) begin
				n = 0;
				for (int dr = -1; dr <= 1; dr++) begin
					for (int dc = -1; dc <= 1; dc++) begin
						rn = (r + dr + DEPTH) % DEPTH;
						cn = (c + dc + WIDTH) % WIDTH;
						// skip the cell itself
						if (dr != 0 || dc != 0) begin
							n = n + int'(board[rn][cn]);
						end
					end
				end
				// birth on 3, survival on 2 or 3
				nb[r][c] = (n == 3) || (n == 2 && board[r][c]);
			end
		end
		board = nb;
		exp_gen = exp_gen + GB'(1);
	endtask

	`include "tb_life_tasks.svh"

	// watchdog, ends a hung run
	initial begin
		int cycles;
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("TESTBENCH FAILED");
		$finish;
	end

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial begin
		reset     = 1'b1;
		cmd       = '0;
		wr_data   = '0;
		errors    = 0;
		checks    = 0;
		tests_run = 0;
		exp_gen   = '0;
		rng_state = 32'd18;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		test_write_readback();
		test_patterns();
		test_random_boards();
		test_run_level();
		test_ignored_requests();

		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
